/* tb.f */
+incdir+common
common/cpc_pkg.sv
rom_loader/rom_loader.sv
multiface/mf2_control.sv
multiface/mf2_ram.sv
rtl/mem_arbiter.sv
rtl/cpc_mem_top.sv
sim/tb_cpc_mem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory-glue testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_cpc_mem -Mdir obj_dir -f tb.f
./obj_dir/Vtb_cpc_mem 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "Testbench reported failure, see sim.log"
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    echo "Run ended without a result line, see sim.log"
    exit 1
fi
echo "Run passed"

/* sim/tb_cpc_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_cpc_mem;
    import cpc_pkg::*;

    typedef enum {OP_RESET, OP_DL, OP_DL_END, OP_IO, OP_M1, OP_NMI,
                  OP_RD_ADDR, OP_RD_DATA, OP_WR} op_t;

    typedef struct {
        op_t         op;
        logic [24:0] addr;      // CPU or download address
        byte_t       data;      // Write data, download index for OP_DL
        logic [31:0] exp;       // SDRAM address, rom_map, flag or byte
        string       label;
    } row_t;

    typedef logic [24:0] mem_key_t;     // {bank, address}

    localparam logic [31:0] NO_WRITE = 32'hFFFF_FFFF;   // Byte must be dropped

    logic      clk_48, RESET;
    logic      ioctl_download, ioctl_wr;
    dl_addr_t  ioctl_addr;
    byte_t     ioctl_dout;
    dl_index_t ioctl_index;
    cpu_addr_t cpu_addr;
    byte_t     cpu_dout, cpu_din, sdram_din, sdram_q;
    mem_addr_t cpu_mem_addr, sdram_addr;
    mem_bank_t sdram_bank;
    logic      mem_rd, mem_wr, io_wr, m1, key_nmi;
    logic      mf2_nmi, sdram_oe, sdram_we;
    rom_map_t  rom_map;

    row_t        rows[$];
    string       cur_label;
    int          err_count;
    int          fail_rows;
    logic [31:0] lfsr;          // Download data source

    cpc_mem_top dut_i (.*);

    initial begin
        clk_48 = 1'b0;
        forever #2 clk_48 = ~clk_48;    // 4 ns period
    end

    // --------------------------------------------------
    // Sparse SDRAM model, one entry per distinct write
    // --------------------------------------------------
    byte_t    sdram_mem [mem_key_t];
    mem_key_t wr_log[$];                // Writes seen during the current row
    logic     prev_we;
    mem_key_t prev_key;
    byte_t    prev_din;

    always @(negedge clk_48) begin
        if (sdram_we && !(prev_we && prev_key == {sdram_bank, sdram_addr}
                          && prev_din == sdram_din)) begin
            sdram_mem[{sdram_bank, sdram_addr}] = sdram_din;
            wr_log.push_back({sdram_bank, sdram_addr});
        end
        prev_we  = sdram_we;
        prev_key = {sdram_bank, sdram_addr};
        prev_din = sdram_din;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);    // Galois form
    endfunction

    task automatic random_byte(output byte_t b);
        b = '0;
        repeat (8) begin
            b    = {b[6:0], lfsr[0]};      // One step per bit
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic drive_point;
        @(posedge clk_48);
        #1;
    endtask

    task automatic check_eq(input string what, input logic [255:0] got,
                            input logic [255:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0.1f ns: %s: %s is %0h, expected %0h",
                     $realtime, cur_label, what, got, exp);
            err_count++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0.1f ns: %s: %s did not arrive", $realtime, cur_label, what);
        err_count++;
    endtask

    // --------------------------------------------------
    // Row operations
    // --------------------------------------------------
    task automatic check_reset_state;
        mem_rd = 1'b1;                  // Held core must not reach SDRAM
        @(negedge clk_48);
        check_eq("sdram_oe", sdram_oe, 1'b0);
        check_eq("sdram_we", sdram_we, 1'b0);
        check_eq("mf2_nmi", mf2_nmi, 1'b0);
        check_eq("rom_map", rom_map, '0);
        drive_point();
        mem_rd = 1'b0;
    endtask

    task automatic download_byte(input dl_addr_t addr, input dl_index_t idx,
                                 input logic [31:0] exp);
        byte_t    data;
        int       n;
        int       copies;
        mem_key_t key;
        random_byte(data);
        copies = (idx >= 8'd1 && idx <= 8'd3) ? 2 : 1;   // Expansion fills both banks
        if (!ioctl_download) begin
            ioctl_index    = idx;
            ioctl_download = 1'b1;
            repeat (2) drive_point();
        end
        wr_log.delete();
        ioctl_addr = addr;
        ioctl_dout = data;
        ioctl_wr   = 1'b1;
        drive_point();
        ioctl_wr = 1'b0;
        n = 0;
        if (exp == NO_WRITE) begin
            repeat (24) drive_point();
            check_eq("write count", wr_log.size(), 0);
        end else begin
            @(negedge clk_48);
            while (!sdram_we && n < 16) begin
                @(negedge clk_48);
                n++;
            end
            if (!sdram_we) report_timeout("SDRAM write");
            while (sdram_we && n < 40) begin
                @(negedge clk_48);
                n++;
            end
            if (sdram_we) report_timeout("end of SDRAM write");
            check_eq("write count", wr_log.size(), copies);
            for (int b = 0; b < copies; b++) begin
                key = {mem_bank_t'(b), exp[22:0]};
                if (b < wr_log.size()) check_eq("write address", wr_log[b], key);
                check_eq("write present", sdram_mem.exists(key), 1'b1);
                if (sdram_mem.exists(key)) check_eq("SDRAM data", sdram_mem[key], data);
            end
            while (n < 24) begin        // Keep strobes well apart
                @(negedge clk_48);
                n++;
            end
            drive_point();
        end
    endtask

    task automatic end_download(input logic [31:0] exp_map);
        ioctl_download = 1'b0;
        repeat (3) drive_point();
        check_eq("rom_map", rom_map, {224'd0, exp_map});
    endtask

    task automatic io_write(input cpu_addr_t addr, input byte_t data);
        cpu_addr = addr;
        cpu_dout = data;
        io_wr    = 1'b1;
        drive_point();
        io_wr = 1'b0;
        repeat (2) drive_point();       // Shadow store lands in RAM
    endtask

    task automatic m1_fetch(input cpu_addr_t addr, input logic exp_nmi);
        cpu_addr     = addr;
        cpu_mem_addr = {7'd0, addr};
        m1           = 1'b1;
        drive_point();
        m1 = 1'b0;
        @(negedge clk_48);
        check_eq("mf2_nmi", mf2_nmi, exp_nmi);
        drive_point();
    endtask

    task automatic press_nmi;
        int n;
        key_nmi = 1'b1;
        drive_point();
        key_nmi = 1'b0;
        n = 0;
        @(negedge clk_48);
        while (!mf2_nmi && n < 8) begin
            @(negedge clk_48);
            n++;
        end
        if (!mf2_nmi) report_timeout("mf2_nmi");
        drive_point();
    endtask

    task automatic read_addr(input cpu_addr_t addr, input logic [31:0] exp);
        cpu_addr     = addr;
        cpu_mem_addr = {7'd0, addr};    // Flat RAM mapping
        mem_rd       = 1'b1;
        @(negedge clk_48);
        check_eq("sdram_oe", sdram_oe, 1'b1);
        check_eq("sdram_addr", sdram_addr, exp[22:0]);
        drive_point();
        mem_rd = 1'b0;
        @(negedge clk_48);
        check_eq("sdram_oe after read", sdram_oe, 1'b0);
        drive_point();
    endtask

    task automatic read_data(input cpu_addr_t addr, input logic [31:0] exp);
        cpu_addr     = addr;
        cpu_mem_addr = {7'd0, addr};
        mem_rd       = 1'b1;
        repeat (2) drive_point();       // Registered RAM read
        @(negedge clk_48);
        check_eq("cpu_din", cpu_din, exp[7:0]);
        check_eq("sdram_oe", sdram_oe, 1'b0);
        drive_point();
        mem_rd = 1'b0;
    endtask

    task automatic mem_write(input cpu_addr_t addr, input byte_t data, input logic exp_we);
        cpu_addr     = addr;
        cpu_mem_addr = {7'd0, addr};
        cpu_dout     = data;
        mem_wr       = 1'b1;
        @(negedge clk_48);
        check_eq("sdram_we", sdram_we, exp_we);
        drive_point();
        mem_wr = 1'b0;
        drive_point();
    endtask

    task automatic add_row(input op_t op, input logic [24:0] addr, input byte_t data,
                           input logic [31:0] exp, input string label);
        row_t r;
        r.op    = op;
        r.addr  = addr;
        r.data  = data;
        r.exp   = exp;
        r.label = label;
        rows.push_back(r);
    endtask

    // --------------------------------------------------
    // Stimulus table
    // --------------------------------------------------
    task automatic build_table;
        add_row(OP_RESET,   25'h0,     8'h00, 32'h0,      "reset state");
        add_row(OP_DL,      25'h00000, 8'd0,  32'h000000, "OS block");
        add_row(OP_DL,      25'h04000, 8'd0,  32'h400000, "BASIC block");
        add_row(OP_DL,      25'h08000, 8'd0,  32'h41C000, "AMSDOS block");
        add_row(OP_DL,      25'h0C000, 8'd0,  32'h3FC000, "MF2 block");
        add_row(OP_DL,      25'h10000, 8'd0,  NO_WRITE,   "beyond 64 KB dropped");
        add_row(OP_DL_END,  25'h0,     8'h00, 32'h81,     "system download end");
        add_row(OP_RD_ADDR, 25'h1234,  8'h00, 32'h001234, "CPU read after boot");
        add_row(OP_DL,      25'h04567, 8'd1,  32'h404567, "expansion page 1");
        add_row(OP_DL,      25'h0B89A, 8'd1,  32'h40B89A, "expansion page 2");
        add_row(OP_DL_END,  25'h0,     8'h00, 32'h87,     "expansion download end");
        add_row(OP_NMI,     25'h0,     8'h00, 32'h1,      "NMI button");
        add_row(OP_M1,      25'h0066,  8'h00, 32'h0,      "M1 at NMI vector");
        add_row(OP_RD_ADDR, 25'h0100,  8'h00, 32'h3FC100, "MF2 ROM read");
        add_row(OP_WR,      25'h0100,  8'h55, 32'h0,      "MF2 ROM write blocked");
        add_row(OP_IO,      25'h7F00,  8'h8C, 32'h0,      "gate array mode");
        add_row(OP_RD_DATA, 25'h3FEF,  8'h00, 32'h8C,     "mode shadow");
        add_row(OP_IO,      25'hBC00,  8'h05, 32'h0,      "CRTC select");
        add_row(OP_IO,      25'hBD00,  8'h2A, 32'h0,      "CRTC value");
        add_row(OP_RD_DATA, 25'h3DB5,  8'h00, 32'h2A,     "CRTC R5 shadow");
        add_row(OP_IO,      25'hFEEA,  8'h00, 32'h0,      "disable port");
        add_row(OP_RD_ADDR, 25'h0100,  8'h00, 32'h000100, "read while disabled");
        add_row(OP_IO,      25'hFEE8,  8'h00, 32'h0,      "enable port");
        add_row(OP_RD_ADDR, 25'h0100,  8'h00, 32'h3FC100, "read while enabled");
        add_row(OP_M1,      25'h0065,  8'h00, 32'h0,      "M1 at hide address");
        add_row(OP_IO,      25'hFEEA,  8'h00, 32'h0,      "disable while hidden");
        add_row(OP_IO,      25'hFEE8,  8'h00, 32'h0,      "enable while hidden");
        add_row(OP_RD_ADDR, 25'h0100,  8'h00, 32'h000100, "hidden stays paged out");
    endtask

    task automatic apply_row(input row_t r);
        case (r.op)
            OP_RESET:   check_reset_state();
            OP_DL:      download_byte(r.addr, r.data, r.exp);
            OP_DL_END:  end_download(r.exp);
            OP_IO:      io_write(r.addr[15:0], r.data);
            OP_M1:      m1_fetch(r.addr[15:0], r.exp[0]);
            OP_NMI:     press_nmi();
            OP_RD_ADDR: read_addr(r.addr[15:0], r.exp);
            OP_RD_DATA: read_data(r.addr[15:0], r.exp);
            default:    mem_write(r.addr[15:0], r.data, r.exp[0]);
        endcase
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        int errs_before;
        RESET          = 1'b1;
        ioctl_download = 1'b0;
        ioctl_wr       = 1'b0;
        ioctl_addr     = '0;
        ioctl_dout     = '0;
        ioctl_index    = '0;
        cpu_addr       = '0;
        cpu_dout       = '0;
        cpu_mem_addr   = '0;
        mem_rd         = 1'b0;
        mem_wr         = 1'b0;
        io_wr          = 1'b0;
        m1             = 1'b0;
        key_nmi        = 1'b0;
        sdram_q        = 8'hFF;         // Model reads back FF
        prev_we        = 1'b0;
        prev_key       = '0;
        prev_din       = '0;
        lfsr           = 32'h3697fa49;
        err_count      = 0;
        fail_rows      = 0;
        build_table();

        repeat (3) @(posedge clk_48);
        #1 RESET = 1'b0;

        foreach (rows[i]) begin
            cur_label   = rows[i].label;
            errs_before = err_count;
            apply_row(rows[i]);
            if (err_count == errs_before) begin
                $display("ok   row %0d  %s", i, rows[i].label);
            end else begin
                $display("FAIL row %0d  %s", i, rows[i].label);
                fail_rows++;
            end
        end

        $display("Rows: %0d, failed rows: %0d, errors: %0d", rows.size(), fail_rows, err_count);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/cpc_mem_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cpc_mem_top (
    input  logic                 clk_48,
    input  logic                 RESET,
    // Download stream
    input  logic                 ioctl_download,
    input  logic                 ioctl_wr,
    input  cpc_pkg::dl_addr_t    ioctl_addr,
    input  cpc_pkg::byte_t       ioctl_dout,
    input  cpc_pkg::dl_index_t   ioctl_index,
    // CPU bus
    input  cpc_pkg::cpu_addr_t   cpu_addr,
    input  cpc_pkg::byte_t       cpu_dout,
    input  cpc_pkg::mem_addr_t   cpu_mem_addr,
    input  logic                 mem_rd,
    input  logic                 mem_wr,
    input  logic                 io_wr,
    input  logic                 m1,
    input  logic                 key_nmi,
    output cpc_pkg::byte_t       cpu_din,
    output logic                 mf2_nmi,
    output cpc_pkg::rom_map_t    rom_map,
    // SDRAM port
    output logic                 sdram_oe,
    output logic                 sdram_we,
    output cpc_pkg::mem_addr_t   sdram_addr,
    output cpc_pkg::mem_bank_t   sdram_bank,
    output cpc_pkg::byte_t       sdram_din,
    input  cpc_pkg::byte_t       sdram_q
);
    import cpc_pkg::*;

    // --------------------------------------------------
    // Loader to arbiter
    logic      boot_wr;
    mem_addr_t boot_addr;
    mem_bank_t boot_bank;
    byte_t     boot_data;
    logic      core_reset;

    // Multiface
    logic      mf2_ram_en, mf2_rom_en;
    byte_t     mf2_dout;
    mf2_addr_t mf2_ram_addr;
    logic      mf2_ram_we;
    byte_t     mf2_ram_data, mf2_ram_q;

    rom_loader loader_i (
        .clk_48(clk_48), .RESET(RESET),
        .ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr),
        .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_index(ioctl_index),
        .boot_wr(boot_wr), .boot_addr(boot_addr), .boot_bank(boot_bank),
        .boot_data(boot_data), .rom_map(rom_map), .core_reset(core_reset)
    );

    mf2_control mf2_ctrl_i (
        .clk_48(clk_48), .RESET(RESET), .core_reset(core_reset),
        .cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .cpu_mem_addr(cpu_mem_addr),
        .mem_rd(mem_rd), .mem_wr(mem_wr), .io_wr(io_wr), .m1(m1), .key_nmi(key_nmi),
        .ram_q(mf2_ram_q), .mf2_nmi(mf2_nmi), .mf2_ram_en(mf2_ram_en),
        .mf2_rom_en(mf2_rom_en), .mf2_dout(mf2_dout), .ram_addr(mf2_ram_addr),
        .ram_we(mf2_ram_we), .ram_data(mf2_ram_data)
    );

    mf2_ram mf2_ram_i (
        .clk_48(clk_48), .addr(mf2_ram_addr), .we(mf2_ram_we),
        .data(mf2_ram_data), .q(mf2_ram_q)
    );

    mem_arbiter arbiter_i (
        .core_reset(core_reset), .boot_wr(boot_wr), .boot_addr(boot_addr),
        .boot_bank(boot_bank), .boot_data(boot_data),
        .cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .cpu_mem_addr(cpu_mem_addr),
        .mem_rd(mem_rd), .mem_wr(mem_wr),
        .mf2_ram_en(mf2_ram_en), .mf2_rom_en(mf2_rom_en), .mf2_dout(mf2_dout),
        .sdram_q(sdram_q), .sdram_oe(sdram_oe), .sdram_we(sdram_we),
        .sdram_addr(sdram_addr), .sdram_bank(sdram_bank), .sdram_din(sdram_din),
        .cpu_din(cpu_din)
    );

endmodule

`default_nettype wire

/* rtl/mem_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpc_defines.svh"

module mem_arbiter (
    input  logic                 core_reset,
    input  logic                 boot_wr,
    input  cpc_pkg::mem_addr_t   boot_addr,
    input  cpc_pkg::mem_bank_t   boot_bank,
    input  cpc_pkg::byte_t       boot_data,
    input  cpc_pkg::cpu_addr_t   cpu_addr,
    input  cpc_pkg::byte_t       cpu_dout,
    input  cpc_pkg::mem_addr_t   cpu_mem_addr,
    input  logic                 mem_rd,
    input  logic                 mem_wr,
    input  logic                 mf2_ram_en,
    input  logic                 mf2_rom_en,
    input  cpc_pkg::byte_t       mf2_dout,
    input  cpc_pkg::byte_t       sdram_q,
    output logic                 sdram_oe,
    output logic                 sdram_we,
    output cpc_pkg::mem_addr_t   sdram_addr,
    output cpc_pkg::mem_bank_t   sdram_bank,
    output cpc_pkg::byte_t       sdram_din,
    output cpc_pkg::byte_t       cpu_din
);
    import cpc_pkg::*;

    logic boot_sel;     // Loader owns the port

    // Cartridge bytes arrive with the core running
    assign boot_sel = core_reset || boot_wr;

    // --------------------------------------------------
    // SDRAM port
    assign sdram_oe   = !boot_sel && mem_rd && !mf2_ram_en;   // MF2 RAM answers itself
    assign sdram_we   = boot_sel ? boot_wr : (mem_wr && !mf2_ram_en && !mf2_rom_en);
    assign sdram_bank = boot_sel ? boot_bank : 2'b00;
    assign sdram_din  = boot_sel ? boot_data : cpu_dout;

    always_comb begin
        if (boot_sel)        sdram_addr = boot_addr;
        else if (mf2_rom_en) sdram_addr = {`CPC_ROM_MF2_PAGE, cpu_addr[13:0]};   // MF2 ROM
        else                 sdram_addr = cpu_mem_addr;
    end

    // Idle sources read as FF
    assign cpu_din = sdram_q & mf2_dout;

endmodule

`default_nettype wire

/* multiface/mf2_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module mf2_ram (
    input  logic                 clk_48,
    input  cpc_pkg::mf2_addr_t   addr,
    input  logic                 we,
    input  cpc_pkg::byte_t       data,
    output cpc_pkg::byte_t       q
);
    import cpc_pkg::*;

    localparam int DEPTH = 2 ** $bits(mf2_addr_t);   // 8192 bytes

    byte_t mem [0:DEPTH-1];

    // --------------------------------------------------
    // Single port, registered read
    always_ff @(posedge clk_48) begin
        if (we) begin
            mem[addr] <= data;
            q         <= data;      // Write-through
        end else begin
            q <= mem[addr];
        end
    end

endmodule

`default_nettype wire

/* multiface/mf2_control.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpc_defines.svh"

module mf2_control (
    input  logic                 clk_48,
    input  logic                 RESET,
    input  logic                 core_reset,
    input  cpc_pkg::cpu_addr_t   cpu_addr,
    input  cpc_pkg::byte_t       cpu_dout,
    input  cpc_pkg::mem_addr_t   cpu_mem_addr,
    input  logic                 mem_rd,
    input  logic                 mem_wr,
    input  logic                 io_wr,
    input  logic                 m1,
    input  logic                 key_nmi,
    input  cpc_pkg::byte_t       ram_q,
    output logic                 mf2_nmi,
    output logic                 mf2_ram_en,
    output logic                 mf2_rom_en,
    output cpc_pkg::byte_t       mf2_dout,
    output cpc_pkg::mf2_addr_t   ram_addr,
    output logic                 ram_we,
    output cpc_pkg::byte_t       ram_data
);
    import cpc_pkg::*;

    mf2_state_t state;
    logic       enabled, hidden;
    logic       en_n, hid_n, nmi_n;
    logic       old_io_wr, old_m1, old_key_nmi;
    logic       io_rise, m1_rise, key_rise;
    logic       port_hit;                   // FEE8 or FEEA
    logic [4:0] pen_index;
    logic [3:0] crtc_reg;
    mf2_addr_t  store_addr;

    assign enabled  = state[0];
    assign hidden   = state[1];
    assign io_rise  = io_wr && !old_io_wr;
    assign m1_rise  = m1 && !old_m1;
    assign key_rise = key_nmi && !old_key_nmi;
    assign port_hit = (cpu_addr[15:2] == `CPC_MF2_PORT_BASE);

    assign mf2_ram_en = enabled && (cpu_addr[15:13] == 3'b001);   // 2000-3FFF
    assign mf2_rom_en = enabled && (cpu_addr[15:13] == 3'b000);   // 0000-1FFF
    assign mf2_dout   = (mf2_ram_en && mem_rd) ? ram_q : 8'hFF;

    // --------------------------------------------------
    // Paging state
    // --------------------------------------------------
    always_comb begin
        en_n  = enabled;
        hid_n = hidden;
        nmi_n = mf2_nmi;
        if (key_rise && !enabled) nmi_n = 1'b1;           // Button pressed
        if (m1_rise && mf2_nmi && (cpu_addr == `CPC_MF2_NMI_VECTOR)) begin
            en_n  = 1'b1;
            hid_n = 1'b0;
            nmi_n = 1'b0;
        end
        if (m1_rise && enabled && (cpu_addr == `CPC_MF2_HIDE_ADDR)) hid_n = 1'b1;
        if (io_rise && port_hit) en_n = !cpu_addr[1] && !hidden;  // FEEA always off
    end

    always_ff @(posedge clk_48) begin
        if (RESET) begin
            old_io_wr   <= 1'b0;
            old_m1      <= 1'b0;
            old_key_nmi <= 1'b0;
        end else begin
            old_io_wr   <= io_wr;
            old_m1      <= m1;
            old_key_nmi <= key_nmi;
        end
        if (RESET || core_reset) begin
            state   <= MF2_OFF;
            mf2_nmi <= 1'b0;
            ram_we  <= 1'b0;
        end else begin
            state   <= mf2_state_t'({hid_n, en_n});
            mf2_nmi <= nmi_n;
            ram_we  <= (io_rise && !port_hit && (store_addr != '0)) || (mem_wr && mf2_ram_en);
        end
    end

    // --------------------------------------------------
    // Shadow store decode
    // --------------------------------------------------
    always_comb begin
        casez ({cpu_addr[15:8], cpu_dout[7:6]})
            {8'h7F, 2'b00}: store_addr = `CPC_MF2_STORE_PEN_IDX;
            {8'h7F, 2'b01}: store_addr = pen_index[4] ? `CPC_MF2_STORE_BORDER
                                         : {`CPC_MF2_STORE_PEN_BASE, pen_index[3:0]};
            {8'h7F, 2'b10}: store_addr = `CPC_MF2_STORE_MODE;
            {8'h7F, 2'b11}: store_addr = `CPC_MF2_STORE_BANK;
            {8'hBC, 2'b??}: store_addr = `CPC_MF2_STORE_CRTC_SEL;
            {8'hBD, 2'b??}: store_addr = {`CPC_MF2_STORE_CRTC_BASE, crtc_reg};
            {8'hF7, 2'b??}: store_addr = `CPC_MF2_STORE_PPI;      // PPI control
            {8'hDF, 2'b??}: store_addr = `CPC_MF2_STORE_ROMSEL;   // Upper ROM select
            default:        store_addr = '0;                      // Not stored
        endcase
    end

    // RAM port, shadow store first, then CPU access
    always_ff @(posedge clk_48) begin
        ram_addr <= cpu_mem_addr[12:0];
        if (io_rise && !port_hit && (store_addr != '0)) begin
            ram_addr <= store_addr;
            ram_data <= cpu_dout;
            if (cpu_addr[15:8] == 8'h7F && cpu_dout[7:6] == 2'b00) pen_index <= cpu_dout[4:0];
            if (cpu_addr[15:8] == 8'hBC) crtc_reg <= cpu_dout[3:0];
        end else if (mem_wr && mf2_ram_en) begin
            ram_data <= cpu_dout;
        end
    end

endmodule

`default_nettype wire

/* rom_loader/rom_loader.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpc_defines.svh"

module rom_loader (
    input  logic                 clk_48,
    input  logic                 RESET,
    input  logic                 ioctl_download,
    input  logic                 ioctl_wr,
    input  cpc_pkg::dl_addr_t    ioctl_addr,
    input  cpc_pkg::byte_t       ioctl_dout,
    input  cpc_pkg::dl_index_t   ioctl_index,
    output logic                 boot_wr,
    output cpc_pkg::mem_addr_t   boot_addr,
    output cpc_pkg::mem_bank_t   boot_bank,
    output cpc_pkg::byte_t       boot_data,
    output cpc_pkg::rom_map_t    rom_map,
    output logic                 core_reset
);
    import cpc_pkg::*;

    logic [`CPC_CE_REF_BITS-1:0] div;     // Reference divider
    logic       ce_ref;
    logic       old_download;
    logic       boot_dup;                  // Current byte goes to both banks
    logic       sys_dl, exp_dl, cart_dl;
    logic       dl_accept;
    logic       dup_next;                  // Start of the bank 1 copy
    logic [8:0] boot_page;

    // --------------------------------------------------
    // Download classification
    // --------------------------------------------------
    assign sys_dl  = (ioctl_index == '0);
    assign exp_dl  = (ioctl_index >= 8'd1) && (ioctl_index <= 8'd3);
    assign cart_dl = (ioctl_index == `CPC_DL_CART_CPR) || (ioctl_index == `CPC_DL_CART_BIN);

    // Only the first 64 KB of an image is used
    assign dl_accept = ioctl_download && ioctl_wr && (ioctl_addr[24:16] == '0)
                       && (sys_dl || exp_dl || cart_dl);

    assign dup_next = ce_ref && boot_wr && boot_dup && !boot_bank[0];

    // Page of the incoming byte
    always_comb begin
        boot_page = {1'b0, ioctl_addr[21:14]};          // Cartridge, lower half
        if (exp_dl) begin
            boot_page = {1'b1, ioctl_addr[21:14]};      // Upper ROM slot
        end else if (sys_dl) begin
            case (ioctl_addr[15:14])                    // 16 KB block in image
                2'd0:    boot_page = `CPC_ROM_OS_PAGE;
                2'd1:    boot_page = `CPC_ROM_BASIC_PAGE;
                2'd2:    boot_page = `CPC_ROM_AMSDOS_PAGE;
                default: boot_page = `CPC_ROM_MF2_PAGE;
            endcase
        end
    end

    // --------------------------------------------------
    // Write strobe, bank repeat, ROM map, core reset
    // --------------------------------------------------
    always_ff @(posedge clk_48) begin
        if (RESET) begin
            div          <= '0;
            ce_ref       <= 1'b0;
            old_download <= 1'b0;
            boot_wr      <= 1'b0;
            boot_dup     <= 1'b0;
            rom_map      <= '0;
            core_reset   <= 1'b1;
        end else begin
            div          <= div + 1'b1;
            ce_ref       <= (div == '0);
            old_download <= ioctl_download;

            if (dl_accept) begin
                boot_wr  <= 1'b1;
                boot_dup <= exp_dl;
            end else if (ce_ref && boot_wr) begin
                if (!dup_next) begin
                    boot_wr <= 1'b0;                    // Second copy keeps boot_wr high
                    if (boot_addr[22]) rom_map[boot_addr[21:14]] <= 1'b1;
                end
            end

            // Hold the core while ROMs load, release for cartridges
            if (!old_download && ioctl_download && (sys_dl || exp_dl)) core_reset <= 1'b1;
            if (!old_download && ioctl_download && cart_dl) core_reset <= 1'b0;
            if (old_download && !ioctl_download) core_reset <= 1'b0;
        end
    end

    // Payload, latched per byte
    always_ff @(posedge clk_48) begin
        if (dl_accept) begin
            boot_data        <= ioctl_dout;
            boot_bank        <= '0;
            boot_addr[22:14] <= boot_page;
            boot_addr[13:0]  <= ioctl_addr[13:0];
        end else if (dup_next) begin
            boot_bank <= 2'd1;                          // Same address, bank 1
        end
    end

endmodule

`default_nettype wire

/* common/cpc_pkg.sv */
`default_nettype none

package cpc_pkg;

    // --------------------------------------------------
    // CPU side
    // --------------------------------------------------
    typedef logic [15:0] cpu_addr_t;    // Z80 address bus
    typedef logic [7:0]  byte_t;        // Data byte, CPU and download

    // --------------------------------------------------
    // SDRAM side
    // --------------------------------------------------
    // Bit 22 upper-ROM half, 21:14 page, 13:0 offset
    typedef logic [22:0] mem_addr_t;
    typedef logic [1:0]  mem_bank_t;

    // Download stream
    typedef logic [24:0] dl_addr_t;     // Byte position in image
    typedef logic [7:0]  dl_index_t;    // Menu slot of the image

    // Multiface
    typedef logic [12:0]  mf2_addr_t;   // 8 KB RAM
    typedef logic [255:0] rom_map_t;    // One bit per upper ROM

    // Multiface paging state, encoded as {hidden, enabled}
    typedef enum logic [1:0] {
        MF2_OFF        = 2'b00,     // Paged out
        MF2_ON         = 2'b01,     // ROM and RAM paged in
        MF2_HIDDEN_OFF = 2'b10,     // Paged out, FEE8 ignored
        MF2_HIDDEN_ON  = 2'b11      // Paged in but hidden
    } mf2_state_t;

endpackage

`default_nettype wire

/* common/cpc_defines.svh */
`ifndef CPC_DEFINES_SVH
`define CPC_DEFINES_SVH

// --------------------------------------------------
// SDRAM pages of the system ROMs, {upper half, page}
`define CPC_ROM_OS_PAGE      9'h000
`define CPC_ROM_BASIC_PAGE   9'h100
`define CPC_ROM_AMSDOS_PAGE  9'h107
`define CPC_ROM_MF2_PAGE     9'h0FF

// Cartridge download slots
`define CPC_DL_CART_CPR      8'd5
`define CPC_DL_CART_BIN      8'd6

// --------------------------------------------------
// Multiface addresses and ports
`define CPC_MF2_NMI_VECTOR   16'h0066
`define CPC_MF2_HIDE_ADDR    16'h0065
`define CPC_MF2_PORT_BASE    14'h3FBA    // FEE8/FEEA with bits 1:0 dropped

// Shadow store locations in Multiface RAM
`define CPC_MF2_STORE_PEN_IDX   13'h1FCF
`define CPC_MF2_STORE_BORDER    13'h1FDF
`define CPC_MF2_STORE_PEN_BASE  9'h1F9     // Low nibble is pen number
`define CPC_MF2_STORE_MODE      13'h1FEF
`define CPC_MF2_STORE_BANK      13'h1FFF
`define CPC_MF2_STORE_CRTC_SEL  13'h1CFF
`define CPC_MF2_STORE_CRTC_BASE 9'h1DB     // Low nibble is CRTC register
`define CPC_MF2_STORE_PPI       13'h17FF
`define CPC_MF2_STORE_ROMSEL    13'h1AAC

`define CPC_CE_REF_BITS      3           // ce_ref every 8 clocks

`endif
